// File: source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int OFFS_W = 12;                              // Offset bits forwarded to slaves.

    localparam logic [ADDR_W-1:0] TIMER_BASE  = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] IRQ_BASE    = 32'h0C00_0000;
    localparam logic [ADDR_W-1:0] UART_BASE   = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] REGION_SIZE = 32'h0000_1000;

    // Core-local timer.
    localparam logic [OFFS_W-1:0] TMR_MSIP = 12'h000;
    localparam logic [OFFS_W-1:0] TMR_CMP  = 12'h004;
    localparam logic [OFFS_W-1:0] TMR_TIME = 12'h008;

    // Interrupt controller, one priority word per source from IRQ_PRIO_BASE.
    localparam logic [OFFS_W-1:0] IRQ_PENDING   = 12'h000;
    localparam logic [OFFS_W-1:0] IRQ_ENABLE    = 12'h004;
    localparam logic [OFFS_W-1:0] IRQ_THRESHOLD = 12'h008;
    localparam logic [OFFS_W-1:0] IRQ_PRIO_BASE = 12'h010;
    localparam logic [OFFS_W-1:0] IRQ_CLAIM     = 12'h020;

    // UART.
    localparam logic [OFFS_W-1:0] UART_DATA   = 12'h000;
    localparam logic [OFFS_W-1:0] UART_STATUS = 12'h004;  // Bit 0 tx_busy, bit 1 rx_valid.
    localparam logic [OFFS_W-1:0] UART_CTRL   = 12'h008;  // Bit 0 rx_irq_enable.

endpackage

`default_nettype wire

// File: source/reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
    parameter int RST_STAGES = 3
) (
    input  logic clk_i,
    input  logic rst_n_i,
    output logic rst_n_o
);

    logic [RST_STAGES-1:0] stage_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;
        end else begin
            stage_q <= {stage_q[RST_STAGES-2:0], 1'b1};  // Ones walk toward the output.
        end
    end

    assign rst_n_o = stage_q[RST_STAGES-1];

endmodule

`default_nettype wire

// File: source/apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [soc_pkg::ADDR_W-1:0] paddr_i,
    input  logic [soc_pkg::DATA_W-1:0] pwdata_i,
    output logic [soc_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    output logic                       tmr_psel_o,
    output logic                       irq_psel_o,
    output logic                       uart_psel_o,
    output logic                       s_penable_o,
    output logic                       s_pwrite_o,
    output logic [soc_pkg::OFFS_W-1:0] s_paddr_o,
    output logic [soc_pkg::DATA_W-1:0] s_pwdata_o,
    input  logic [soc_pkg::DATA_W-1:0] tmr_prdata_i,
    input  logic [soc_pkg::DATA_W-1:0] irq_prdata_i,
    input  logic [soc_pkg::DATA_W-1:0] uart_prdata_i,
    input  logic                       tmr_pready_i,
    input  logic                       irq_pready_i,
    input  logic                       uart_pready_i
);
    import soc_pkg::*;

    logic              tmr_hit;
    logic              irq_hit;
    logic              uart_hit;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] offset;

    function automatic logic in_region(input logic [ADDR_W-1:0] addr,
                                       input logic [ADDR_W-1:0] region_base);
        return (addr >= region_base) && (addr < region_base + REGION_SIZE);
    endfunction

    assign tmr_hit  = in_region(paddr_i, TIMER_BASE);
    assign irq_hit  = in_region(paddr_i, IRQ_BASE);
    assign uart_hit = in_region(paddr_i, UART_BASE);

    assign tmr_psel_o  = psel_i & tmr_hit;
    assign irq_psel_o  = psel_i & irq_hit;
    assign uart_psel_o = psel_i & uart_hit;

    always_comb begin
        base = '0;
        if (tmr_hit) begin
            base = TIMER_BASE;
        end else if (irq_hit) begin
            base = IRQ_BASE;
        end else if (uart_hit) begin
            base = UART_BASE;
        end
    end

    assign offset      = paddr_i - base;
    assign s_paddr_o   = offset[OFFS_W-1:0];
    assign s_penable_o = penable_i;
    assign s_pwrite_o  = pwrite_i;
    assign s_pwdata_o  = pwdata_i;

    always_comb begin
        prdata_o  = '0;
        pready_o  = 1'b1;
        pslverr_o = 1'b0;
        if (tmr_hit) begin
            prdata_o = tmr_prdata_i;
            pready_o = tmr_pready_i;
        end else if (irq_hit) begin
            prdata_o = irq_prdata_i;
            pready_o = irq_pready_i;
        end else if (uart_hit) begin
            prdata_o = uart_prdata_i;
            pready_o = uart_pready_i;
        end else begin
            pslverr_o = psel_i;                          // Unmapped address.
        end
    end

endmodule

`default_nettype wire

// File: source/core_timer.sv
`timescale 1ns/1ps
`default_nettype none

module core_timer #(
    parameter int RTC_DIV = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [soc_pkg::OFFS_W-1:0] paddr_i,
    input  logic [soc_pkg::DATA_W-1:0] pwdata_i,
    output logic [soc_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       timer_irq_o,
    output logic                       soft_irq_o
);
    import soc_pkg::*;

    localparam int CNT_W = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

    logic [CNT_W-1:0]  tick_cnt_q;
    logic              tick;
    logic              wr_en;
    logic [DATA_W-1:0] mtime_q;
    logic [DATA_W-1:0] mtimecmp_q;
    logic              msip_q;

    assign wr_en = psel_i & penable_i & pwrite_i;
    assign tick  = (tick_cnt_q == CNT_W'(RTC_DIV - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tick_cnt_q <= '0;
        end else if (tick) begin
            tick_cnt_q <= '0;
        end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_o <= 1'b0;
        end else begin
            if (wr_en && paddr_i == TMR_TIME) begin
                mtime_q <= pwdata_i;                     // Software write wins over the tick.
            end else if (tick) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr_en && paddr_i == TMR_CMP) begin
                mtimecmp_q <= pwdata_i;
            end
            if (wr_en && paddr_i == TMR_MSIP) begin
                msip_q <= pwdata_i[0];
            end
            timer_irq_o <= (mtime_q >= mtimecmp_q);
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            TMR_MSIP: prdata_o[0] = msip_q;
            TMR_CMP:  prdata_o    = mtimecmp_q;
            TMR_TIME: prdata_o    = mtime_q;
            default:  prdata_o    = '0;
        endcase
    end

    assign pready_o   = 1'b1;
    assign soft_irq_o = msip_q;

endmodule

`default_nettype wire

// File: source/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl #(
    parameter int IRQ_NUM = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [soc_pkg::OFFS_W-1:0] paddr_i,
    input  logic [soc_pkg::DATA_W-1:0] pwdata_i,
    input  logic [IRQ_NUM-1:0]         src_i,
    output logic [soc_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       ext_irq_o
);
    import soc_pkg::*;

    localparam int ID_W = $clog2(IRQ_NUM + 1);

    logic [IRQ_NUM-1:0] pend_q;
    logic [IRQ_NUM-1:0] claimed_q;
    logic [IRQ_NUM-1:0] enable_q;
    logic [IRQ_NUM-1:0] pend_vis;
    logic [1:0]         prio_q [IRQ_NUM];
    logic [1:0]         threshold_q;
    logic [1:0]         best_prio;
    logic [ID_W-1:0]    best_id;
    logic               wr_en;
    logic               claim_rd;

    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign claim_rd = psel_i & penable_i & ~pwrite_i & (paddr_i == IRQ_CLAIM);
    assign pend_vis = pend_q & ~claimed_q;               // Claimed sources are hidden.

    // Strict compare keeps the lowest ID on equal priority.
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        for (int i = 0; i < IRQ_NUM; i++) begin
            if (pend_vis[i] && enable_q[i] && prio_q[i] > best_prio) begin
                best_id   = ID_W'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q      <= '0;
            claimed_q   <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
            ext_irq_o   <= 1'b0;
            for (int i = 0; i < IRQ_NUM; i++) begin
                prio_q[i] <= '0;
            end
        end else begin
            pend_q    <= src_i;
            ext_irq_o <= (best_id != '0);
            if (wr_en && paddr_i == IRQ_ENABLE) begin
                enable_q <= pwdata_i[IRQ_NUM-1:0];
            end
            if (wr_en && paddr_i == IRQ_THRESHOLD) begin
                threshold_q <= pwdata_i[1:0];
            end
            for (int i = 0; i < IRQ_NUM; i++) begin
                if (wr_en && paddr_i == OFFS_W'(IRQ_PRIO_BASE + 4 * i)) begin
                    prio_q[i] <= pwdata_i[1:0];
                end
                if (claim_rd && best_id == ID_W'(i + 1)) begin
                    claimed_q[i] <= 1'b1;
                end
                if (wr_en && paddr_i == IRQ_CLAIM && pwdata_i == DATA_W'(i + 1)) begin
                    claimed_q[i] <= 1'b0;                // Complete.
                end
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            IRQ_PENDING:   prdata_o[IRQ_NUM-1:0] = pend_vis;
            IRQ_ENABLE:    prdata_o[IRQ_NUM-1:0] = enable_q;
            IRQ_THRESHOLD: prdata_o[1:0]         = threshold_q;
            IRQ_CLAIM:     prdata_o[ID_W-1:0]    = best_id;
            default: begin
                for (int i = 0; i < IRQ_NUM; i++) begin
                    if (paddr_i == OFFS_W'(IRQ_PRIO_BASE + 4 * i)) begin
                        prdata_o[1:0] = prio_q[i];
                    end
                end
            end
        endcase
    end

    assign pready_o = 1'b1;

endmodule

`default_nettype wire

// File: source/uart_lite.sv
`timescale 1ns/1ps
`default_nettype none

module uart_lite #(
    parameter int UART_DIV = 16
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [soc_pkg::OFFS_W-1:0] paddr_i,
    input  logic [soc_pkg::DATA_W-1:0] pwdata_i,
    input  logic                       rxd_i,
    output logic [soc_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       txd_o,
    output logic                       irq_o
);
    import soc_pkg::*;

    localparam int DIV_W = $clog2(UART_DIV);

    logic             tx_busy_q;
    logic [DIV_W-1:0] tx_div_q;
    logic [3:0]       tx_bits_q;
    logic [8:0]       tx_shift_q;
    logic [2:0]       rx_sync_q;
    logic             rx_busy_q;
    logic [DIV_W-1:0] rx_div_q;
    logic [3:0]       rx_bits_q;
    logic [7:0]       rx_shift_q;
    logic [7:0]       rx_data_q;
    logic             rx_valid_q;
    logic             rx_irq_en_q;
    logic             wr_en;
    logic             data_rd;
    logic             rx_mid;

    assign wr_en   = psel_i & penable_i & pwrite_i;
    assign data_rd = psel_i & penable_i & ~pwrite_i & (paddr_i == UART_DATA);
    assign rx_mid  = (rx_div_q == DIV_W'(UART_DIV / 2 - 1));

    // Bit periods 0 start, 1 to 8 data, 9 stop.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tx_busy_q <= 1'b0;
            txd_o     <= 1'b1;
            tx_div_q  <= '0;
            tx_bits_q <= '0;
        end else if (!tx_busy_q) begin
            if (wr_en && paddr_i == UART_DATA) begin
                tx_busy_q  <= 1'b1;
                txd_o      <= 1'b0;
                tx_shift_q <= {1'b1, pwdata_i[7:0]};
                tx_div_q   <= '0;
                tx_bits_q  <= '0;
            end
        end else if (tx_div_q == DIV_W'(UART_DIV - 1)) begin
            tx_div_q <= '0;
            if (tx_bits_q == 4'd9) begin
                tx_busy_q <= 1'b0;
                txd_o     <= 1'b1;
            end else begin
                txd_o      <= tx_shift_q[0];
                tx_shift_q <= {1'b1, tx_shift_q[8:1]};
                tx_bits_q  <= tx_bits_q + 1'b1;
            end
        end else begin
            tx_div_q <= tx_div_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_sync_q   <= 3'b111;
            rx_busy_q   <= 1'b0;
            rx_div_q    <= '0;
            rx_bits_q   <= '0;
            rx_data_q   <= '0;
            rx_valid_q  <= 1'b0;
            rx_irq_en_q <= 1'b0;
        end else begin
            rx_sync_q <= {rx_sync_q[1:0], rxd_i};
            if (data_rd) begin
                rx_valid_q <= 1'b0;
            end
            if (wr_en && paddr_i == UART_CTRL) begin
                rx_irq_en_q <= pwdata_i[0];
            end
            if (!rx_busy_q) begin
                if (rx_sync_q[2] && !rx_sync_q[1]) begin  // Falling edge of the start bit.
                    rx_busy_q <= 1'b1;
                    rx_div_q  <= '0;
                    rx_bits_q <= '0;
                end
            end else begin
                rx_div_q <= (rx_div_q == DIV_W'(UART_DIV - 1)) ? '0 : rx_div_q + 1'b1;
                if (rx_div_q == DIV_W'(UART_DIV - 1)) begin
                    rx_bits_q <= rx_bits_q + 1'b1;
                end
                if (rx_mid) begin
                    if (rx_bits_q == 4'd0 && rx_sync_q[1]) begin
                        rx_busy_q <= 1'b0;               // Glitch, not a start bit.
                    end else if (rx_bits_q == 4'd9) begin
                        rx_busy_q  <= 1'b0;
                        rx_data_q  <= rx_shift_q;
                        rx_valid_q <= 1'b1;
                    end else if (rx_bits_q != 4'd0) begin
                        rx_shift_q <= {rx_sync_q[1], rx_shift_q[7:1]};
                    end
                end
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            UART_DATA:   prdata_o[7:0] = rx_data_q;
            UART_STATUS: prdata_o[1:0] = {rx_valid_q, tx_busy_q};
            UART_CTRL:   prdata_o[0]   = rx_irq_en_q;
            default:     prdata_o      = '0;
        endcase
    end

    assign pready_o = 1'b1;
    assign irq_o    = rx_valid_q & rx_irq_en_q;

endmodule

`default_nettype wire

// File: source/soc_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
    parameter int RST_STAGES = 3,
    parameter int RTC_DIV    = 8,
    parameter int UART_DIV   = 16,
    parameter int IRQ_NUM    = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [soc_pkg::ADDR_W-1:0] paddr_i,
    input  logic [soc_pkg::DATA_W-1:0] pwdata_i,
    output logic [soc_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  logic                       ext_irq_i,
    input  logic                       rxd_i,
    output logic                       txd_o,
    output logic                       timer_irq_o,
    output logic                       soft_irq_o,
    output logic                       ext_irq_o
);
    import soc_pkg::*;

    logic               sys_rst_n;                       // Bus side and interrupt blocks.
    logic               periph_rst_n;
    logic               tmr_psel;
    logic               irq_psel;
    logic               uart_psel;
    logic               s_penable;
    logic               s_pwrite;
    logic [OFFS_W-1:0]  s_paddr;
    logic [DATA_W-1:0]  s_pwdata;
    logic [DATA_W-1:0]  tmr_prdata;
    logic [DATA_W-1:0]  irq_prdata;
    logic [DATA_W-1:0]  uart_prdata;
    logic               tmr_pready;
    logic               irq_pready;
    logic               uart_pready;
    logic               uart_irq;
    logic [IRQ_NUM-1:0] irq_src;

    assign irq_src = IRQ_NUM'({ext_irq_i, uart_irq});   // ID 1 is the UART, ID 2 external.

    reset_sync #(.RST_STAGES(RST_STAGES)) u_sys_rst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .rst_n_o(sys_rst_n)
    );

    reset_sync #(.RST_STAGES(RST_STAGES)) u_periph_rst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .rst_n_o(periph_rst_n)
    );

    apb_decoder u_decoder (
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .tmr_psel_o(tmr_psel), .irq_psel_o(irq_psel), .uart_psel_o(uart_psel),
        .s_penable_o(s_penable), .s_pwrite_o(s_pwrite),
        .s_paddr_o(s_paddr), .s_pwdata_o(s_pwdata),
        .tmr_prdata_i(tmr_prdata), .irq_prdata_i(irq_prdata), .uart_prdata_i(uart_prdata),
        .tmr_pready_i(tmr_pready), .irq_pready_i(irq_pready), .uart_pready_i(uart_pready)
    );

    core_timer #(.RTC_DIV(RTC_DIV)) u_timer (
        .clk_i(clk_i), .rst_n_i(sys_rst_n),
        .psel_i(tmr_psel), .penable_i(s_penable), .pwrite_i(s_pwrite),
        .paddr_i(s_paddr), .pwdata_i(s_pwdata),
        .prdata_o(tmr_prdata), .pready_o(tmr_pready),
        .timer_irq_o(timer_irq_o), .soft_irq_o(soft_irq_o)
    );

    irq_ctrl #(.IRQ_NUM(IRQ_NUM)) u_irq_ctrl (
        .clk_i(clk_i), .rst_n_i(sys_rst_n),
        .psel_i(irq_psel), .penable_i(s_penable), .pwrite_i(s_pwrite),
        .paddr_i(s_paddr), .pwdata_i(s_pwdata), .src_i(irq_src),
        .prdata_o(irq_prdata), .pready_o(irq_pready), .ext_irq_o(ext_irq_o)
    );

    uart_lite #(.UART_DIV(UART_DIV)) u_uart (
        .clk_i(clk_i), .rst_n_i(periph_rst_n),
        .psel_i(uart_psel), .penable_i(s_penable), .pwrite_i(s_pwrite),
        .paddr_i(s_paddr), .pwdata_i(s_pwdata), .rxd_i(rxd_i),
        .prdata_o(uart_prdata), .pready_o(uart_pready),
        .txd_o(txd_o), .irq_o(uart_irq)
    );

endmodule

`default_nettype wire

// File: tests/tb_apb_tasks.svh
task automatic next_slot();
    @(posedge clk);
    #1;                                                  // Inputs change just after the edge.
endtask

task automatic apb_transfer(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    next_slot();
    penable = 1'b1;
    @(negedge clk);
    if (!pready) begin
        errors++;
        $display("Error at time %0t: pready is low in the access cycle to %h", $time, addr);
    end
    while (!pready) begin
        @(negedge clk);
    end
    rdata      = prdata;                                 // Taken mid-cycle, before the completing edge.
    err        = pslverr;
    read_cycle = cycles;
    next_slot();
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    if (err) begin
        errors++;
        $display("Error at time %0t: write to %h was answered with pslverr", $time, addr);
    end
endtask

task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

// Start bit, eight data bits LSB first, stop bit.
task automatic send_frame(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
        rxd = frame[i];
        repeat (UART_DIV) @(posedge clk);
        #1;
    end
endtask

task automatic capture_frame(output logic [7:0] data, output logic stop_bit);
    @(negedge clk);
    while (txd) begin
        @(negedge clk);
    end
    repeat (UART_DIV / 2) @(negedge clk);                // Middle of the start bit.
    for (int i = 0; i < 8; i++) begin
        repeat (UART_DIV) @(negedge clk);
        data[i] = txd;
    end
    repeat (UART_DIV) @(negedge clk);
    stop_bit = txd;
    next_slot();
endtask

// File: tests/tb_soc_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;
    import soc_pkg::*;

    localparam int RTC_DIV  = 8;
    localparam int UART_DIV = 16;
    localparam int TIMEOUT  = 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        ext_src;
    logic        rxd;
    logic        txd;
    logic        timer_irq;
    logic        soft_irq;
    logic        ext_irq;
    int unsigned cycles = 0;
    int unsigned read_cycle = 0;
    int unsigned errors = 0;
    int unsigned checks = 0;
    logic [1:0]  en_m;                                   // Mirrors of the interrupt controller.
    logic [1:0]  prio_m [2];
    logic [1:0]  thr_m;

    soc_periph_top #(.RTC_DIV(RTC_DIV), .UART_DIV(UART_DIV)) u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .ext_irq_i(ext_src), .rxd_i(rxd), .txd_o(txd),
        .timer_irq_o(timer_irq), .soft_irq_o(soft_irq), .ext_irq_o(ext_irq)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    `include "tb_apb_tasks.svh"

    task automatic expect_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_near(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got + 1 < exp || got > exp + 1) begin
            errors++;
            $display("Error at time %0t: %s is %0d, expected %0d +/- 1", $time, what, got, exp);
        end
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        expect_word(what, data, exp);
        expect_word({what, " pslverr"}, 32'(err), 0);
    endtask

    task automatic wait_cycle(input int unsigned target);
        @(negedge clk);
        while (cycles < target) begin
            @(negedge clk);
        end
    endtask

    task automatic program_irq();
        apb_write(IRQ_BASE + IRQ_PRIO_BASE, 32'(prio_m[0]));
        apb_write(IRQ_BASE + IRQ_PRIO_BASE + 4, 32'(prio_m[1]));
        apb_write(IRQ_BASE + IRQ_THRESHOLD, 32'(thr_m));
        apb_write(IRQ_BASE + IRQ_ENABLE, 32'(en_m));
    endtask

    function automatic logic mapped(input logic [31:0] addr);
        return (addr - TIMER_BASE < REGION_SIZE) || (addr - IRQ_BASE < REGION_SIZE)
            || (addr - UART_BASE < REGION_SIZE);
    endfunction

    // Scanning from the highest ID with >= leaves the lowest ID on a tie.
    function automatic int unsigned model_winner(input logic [1:0] visible);
        int unsigned id;
        logic [1:0]  top;
        id  = 0;
        top = 2'd0;
        for (int i = 1; i >= 0; i--) begin
            if (visible[i] && en_m[i] && prio_m[i] > thr_m && prio_m[i] >= top) begin
                id  = i + 1;
                top = prio_m[i];
            end
        end
        return id;
    endfunction

    initial begin
        logic [31:0] data;
        logic [31:0] value;
        logic        err;
        logic        stop_bit;
        logic [7:0]  tx_byte;
        logic [7:0]  rx_byte;
        logic [1:0]  claimed;
        int unsigned mark;
        int unsigned win;
        int unsigned win2;
        void'($urandom(88));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ext_src = 1'b0;
        rxd     = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        mark  = cycles;                                  // mtime counts from here.
        repeat (5) @(posedge clk);
        @(negedge clk);
        expect_word("txd and interrupt lines", 32'({txd, timer_irq, soft_irq, ext_irq}), 32'h8);
        next_slot();
        apb_read(TIMER_BASE + TMR_TIME, data, err);
        expect_near("mtime after reset", data, (read_cycle - mark) / RTC_DIV);
        read_check(TIMER_BASE + TMR_MSIP, 0, "msip reset");
        read_check(TIMER_BASE + TMR_CMP, 32'hffff_ffff, "mtimecmp reset");
        read_check(IRQ_BASE + IRQ_PENDING, 0, "pending reset");
        read_check(IRQ_BASE + IRQ_ENABLE, 0, "enable reset");
        read_check(IRQ_BASE + IRQ_THRESHOLD, 0, "threshold reset");
        read_check(IRQ_BASE + IRQ_PRIO_BASE, 0, "priority 1 reset");
        read_check(IRQ_BASE + IRQ_PRIO_BASE + 4, 0, "priority 2 reset");
        read_check(IRQ_BASE + IRQ_CLAIM, 0, "claim reset");
        read_check(UART_BASE + UART_STATUS, 0, "uart status reset");
        read_check(UART_BASE + UART_CTRL, 0, "uart ctrl reset");
        data = $urandom;
        apb_write(TIMER_BASE + TMR_CMP, data);
        read_check(TIMER_BASE + TMR_CMP, data, "mtimecmp readback");
        for (int n = 0; n < 4; n++) begin
            en_m      = 2'($urandom);
            thr_m     = 2'($urandom);
            prio_m[0] = 2'($urandom);
            prio_m[1] = 2'($urandom);
            program_irq();
            read_check(IRQ_BASE + IRQ_ENABLE, 32'(en_m), "enable readback");
            read_check(IRQ_BASE + IRQ_THRESHOLD, 32'(thr_m), "threshold readback");
            read_check(IRQ_BASE + IRQ_PRIO_BASE, 32'(prio_m[0]), "priority 1 readback");
            read_check(IRQ_BASE + IRQ_PRIO_BASE + 4, 32'(prio_m[1]), "priority 2 readback");
        end
        for (int n = 0; n < 8; n++) begin
            value = $urandom;
            while (mapped(value)) begin
                value = $urandom;
            end
            apb_read(value, data, err);
            expect_word("pslverr on unmapped read", 32'(err), 1);
            expect_word("prdata on unmapped read", data, 0);
        end

        value = $urandom_range(1000, 0);
        apb_write(TIMER_BASE + TMR_TIME, value);
        mark = cycles;
        repeat ($urandom_range(60, 5)) @(posedge clk);
        #1;
        apb_read(TIMER_BASE + TMR_TIME, data, err);
        expect_near("mtime after write", data, value + (read_cycle - mark) / RTC_DIV);
        mark = read_cycle;                               // mtime equals data at this cycle.
        apb_write(TIMER_BASE + TMR_CMP, data + 4);
        wait_cycle(mark + 3 * RTC_DIV);
        expect_word("timer_irq before mtimecmp", 32'(timer_irq), 0);
        wait_cycle(mark + 5 * RTC_DIV);
        expect_word("timer_irq after mtimecmp", 32'(timer_irq), 1);
        next_slot();
        apb_write(TIMER_BASE + TMR_MSIP, 1);
        @(negedge clk);
        expect_word("soft_irq set", 32'(soft_irq), 1);
        next_slot();
        apb_write(TIMER_BASE + TMR_MSIP, 0);
        @(negedge clk);
        expect_word("soft_irq cleared", 32'(soft_irq), 0);
        next_slot();

        for (int n = 0; n < 8; n++) begin
            data = 32'h1;
            while (data[0]) begin
                apb_read(UART_BASE + UART_STATUS, data, err);
            end
            tx_byte = 8'($urandom);
            apb_write(UART_BASE + UART_DATA, {24'h0, tx_byte});
            capture_frame(rx_byte, stop_bit);
            expect_word("txd data bits", {24'h0, rx_byte}, {24'h0, tx_byte});
            expect_word("txd stop bit", 32'(stop_bit), 1);
        end

        en_m      = 2'b01;                               // Only the UART source, priority 1.
        thr_m     = 2'd0;
        prio_m[0] = 2'd1;
        prio_m[1] = 2'd0;
        program_irq();
        apb_write(UART_BASE + UART_CTRL, 1);
        for (int n = 0; n < 8; n++) begin
            tx_byte = 8'($urandom);
            send_frame(tx_byte);
            read_check(UART_BASE + UART_STATUS, 32'h2, "status after receive");
            @(negedge clk);
            expect_word("ext_irq on receive", 32'(ext_irq), 1);
            next_slot();
            read_check(UART_BASE + UART_DATA, {24'h0, tx_byte}, "received byte");
            read_check(UART_BASE + UART_STATUS, 0, "status after data read");
        end

        for (int n = 0; n < 4; n++) begin
            en_m      = 2'($urandom_range(3, 1));
            thr_m     = 2'($urandom_range(2, 0));
            prio_m[0] = 2'($urandom);
            prio_m[1] = 2'($urandom);
            program_irq();
            ext_src = 1'b1;
            send_frame(8'($urandom));                    // Left unread so source 1 stays high.
            win = model_winner(2'b11);
            wait_cycle(cycles + 3);
            expect_word("ext_irq with both sources", 32'(ext_irq), 32'(win != 0));
            next_slot();
            read_check(IRQ_BASE + IRQ_CLAIM, win, "first claim");
            claimed = (win == 0) ? 2'b00 : 2'(1 << (win - 1));
            read_check(IRQ_BASE + IRQ_PENDING, 32'(2'b11 & ~claimed), "pending after claim");
            win2 = model_winner(~claimed);
            read_check(IRQ_BASE + IRQ_CLAIM, win2, "second claim");
            ext_src = 1'b0;
            apb_read(UART_BASE + UART_DATA, data, err);
            apb_write(IRQ_BASE + IRQ_CLAIM, win);
            apb_write(IRQ_BASE + IRQ_CLAIM, win2);
            wait_cycle(cycles + 3);
            expect_word("ext_irq after complete", 32'(ext_irq), 0);
            next_slot();
            read_check(IRQ_BASE + IRQ_PENDING, 0, "pending after complete");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_periph.f
+incdir+tests
source/soc_pkg.sv
source/reset_sync.sv
source/apb_decoder.sv
source/core_timer.sv
source/irq_ctrl.sv
source/uart_lite.sv
source/soc_periph_top.sv
tests/tb_soc_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f soc_periph.f --top-module tb_soc_periph -o tb_soc_periph \
    && ./obj_dir/tb_soc_periph > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run of the simulation did not complete."; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported a failure."; exit 1; }
echo "Simulation finished without failures."
exit 0
